//--- common/eth_rx_cfg.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build constants for the receive MAC
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// Lanes per XGMII word
`define ETH_RX_DATA_BYTES 4

// Frame FIFO depth in words
`define ETH_RX_FIFO_DEPTH 32

// Shortest legal frame, FCS included
`define ETH_MIN_FRAME_BYTES 64

// Width of each statistics counter
`define ETH_STAT_WIDTH 16

`endif

//--- common/eth_rx_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus types, XGMII codes and CRC-32 step
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "eth_rx_cfg.svh"

package eth_rx_pkg;

    typedef logic [8*`ETH_RX_DATA_BYTES-1:0] rx_data_t;
    typedef logic [`ETH_RX_DATA_BYTES-1:0]   rx_keep_t;
    typedef logic [`ETH_RX_DATA_BYTES-1:0]   xgmii_ctrl_t;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;
    localparam logic [7:0] ETH_SFD     = 8'hD5;

    localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
    // Good-frame residue, written MSB first
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

    // One byte of reflected CRC-32, LSB of the byte first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hEDB8_8320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

//--- mac_rx/xgmii_rx_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII lane decoder with preamble strip
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "eth_rx_cfg.svh"

module xgmii_rx_decode (
    input  logic                    rx_clk,
    input  logic                    rx_rst,
    input  eth_rx_pkg::rx_data_t    xgmii_rxd,
    input  eth_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    input  logic                    rx_enable,
    output eth_rx_pkg::rx_data_t    dec_data,
    output eth_rx_pkg::rx_keep_t    dec_keep,
    output logic                    dec_valid,
    output logic                    dec_last,
    output logic                    dec_err,
    output logic                    in_frame
);
    import eth_rx_pkg::*;

    localparam int LANES = `ETH_RX_DATA_BYTES;
    localparam int POS_W = $clog2(LANES + 1);
    localparam int CNT_W = $clog2(`ETH_MIN_FRAME_BYTES + LANES) + 1;

    typedef enum logic [1:0] {ST_IDLE, ST_PREAMBLE, ST_DATA} state_t;

    state_t           state;
    rx_data_t         hold_data;
    rx_keep_t         hold_keep;
    logic             hold_valid;
    logic             hold_last;
    logic             err_acc;
    logic [CNT_W-1:0] byte_cnt;
    logic [POS_W-1:0] term_pos;
    rx_keep_t         new_keep;
    logic             ctrl_err;
    logic             start_det;
    logic             sfd_ok;

    // Lane of the first terminate, LANES when absent
    always_comb begin
        term_pos = POS_W'(LANES);
        ctrl_err = 1'b0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (xgmii_rxc[i] && xgmii_rxd[8*i +: 8] == XGMII_TERM) begin
                term_pos = POS_W'(i);
            end
        end
        for (int i = 0; i < LANES; i++) begin
            new_keep[i] = (i < term_pos);
            if (i < term_pos && xgmii_rxc[i]) begin
                ctrl_err = 1'b1;
            end
        end
    end

    assign start_det = xgmii_rxc[0] && xgmii_rxd[7:0] == XGMII_START;
    assign sfd_ok    = !xgmii_rxc[LANES-1] && xgmii_rxd[8*LANES-1 -: 8] == ETH_SFD;

    // Terminate in lane 0 closes the word already held
    assign dec_data  = hold_data;
    assign dec_keep  = hold_keep;
    assign dec_valid = hold_valid;
    assign dec_last  = hold_valid && (hold_last || (state == ST_DATA && term_pos == '0));
    assign dec_err   = dec_last && (err_acc || byte_cnt < CNT_W'(`ETH_MIN_FRAME_BYTES));
    assign in_frame  = (state != ST_IDLE);

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state      <= ST_IDLE;
            hold_valid <= 1'b0;
            hold_last  <= 1'b0;
            err_acc    <= 1'b0;
            byte_cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    hold_valid <= 1'b0;
                    if (rx_enable && start_det) begin
                        state    <= ST_PREAMBLE;
                        err_acc  <= 1'b0;
                        byte_cnt <= '0;
                    end
                end
                ST_PREAMBLE: begin
                    hold_valid <= 1'b0;
                    err_acc    <= !sfd_ok;
                    state      <= ST_DATA;
                end
                default: begin
                    hold_valid <= (term_pos != '0);
                    hold_last  <= (term_pos != POS_W'(LANES));
                    if (ctrl_err) begin
                        err_acc <= 1'b1;
                    end
                    // Count only up to the runt limit
                    if (byte_cnt < CNT_W'(`ETH_MIN_FRAME_BYTES)) begin
                        byte_cnt <= byte_cnt + CNT_W'(term_pos);
                    end
                    if (term_pos != POS_W'(LANES)) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge rx_clk) begin
        if (state == ST_DATA) begin
            hold_data <= xgmii_rxd;
            hold_keep <= new_keep;
        end
    end

endmodule

//--- mac_rx/rx_fcs_check.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FCS residue check and FCS strip
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "eth_rx_cfg.svh"

module rx_fcs_check (
    input  logic                 rx_clk,
    input  logic                 rx_rst,
    input  eth_rx_pkg::rx_data_t dec_data,
    input  eth_rx_pkg::rx_keep_t dec_keep,
    input  logic                 dec_valid,
    input  logic                 dec_last,
    input  logic                 dec_err,
    output eth_rx_pkg::rx_data_t fcs_data,
    output eth_rx_pkg::rx_keep_t fcs_keep,
    output logic                 fcs_valid,
    output logic                 fcs_last,
    output logic                 fcs_bad,
    output logic                 fcs_err
);
    import eth_rx_pkg::*;

    localparam int LANES = `ETH_RX_DATA_BYTES;

    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic [31:0] crc_msb_first;
    rx_data_t    held_data;
    logic        held_valid;

    // CRC over the valid lanes of the incoming word
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < LANES; i++) begin
            if (dec_keep[i]) begin
                crc_next = crc32_byte(crc_next, dec_data[8*i +: 8]);
            end
        end
        crc_msb_first = {<<{crc_next}};
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_state  <= CRC_INIT;
            held_valid <= 1'b0;
            fcs_valid  <= 1'b0;
            fcs_last   <= 1'b0;
            fcs_bad    <= 1'b0;
            fcs_err    <= 1'b0;
        end else begin
            fcs_valid <= dec_valid && (held_valid || dec_last);
            fcs_last  <= dec_valid && dec_last;
            fcs_bad   <= dec_valid && dec_last && (crc_msb_first != CRC_RESIDUE);
            // A lone final word can only be a runt
            fcs_err   <= dec_valid && dec_last && (dec_err || !held_valid);
            if (dec_valid) begin
                held_valid <= !dec_last;
                crc_state  <= dec_last ? CRC_INIT : crc_next;
            end
        end
    end

    // Final word is dropped, its keep moves to the held word
    always_ff @(posedge rx_clk) begin
        if (dec_valid) begin
            held_data <= dec_data;
            fcs_data  <= held_valid ? held_data : dec_data;
            fcs_keep  <= dec_last ? dec_keep : '1;
        end
    end

endmodule

//--- logic/rx_ctrl_stats.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive enable and frame counters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "eth_rx_cfg.svh"

module rx_ctrl_stats (
    input  logic                       rx_clk,
    input  logic                       rx_rst,
    input  logic                       cfg_rx_enable,
    input  logic                       in_frame,
    input  logic                       frame_good,
    input  logic                       frame_drop,
    output logic                       rx_enable,
    output logic [`ETH_STAT_WIDTH-1:0] stat_good_frames,
    output logic [`ETH_STAT_WIDTH-1:0] stat_dropped_frames
);

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            rx_enable           <= 1'b1;
            stat_good_frames    <= '0;
            stat_dropped_frames <= '0;
        end else begin
            // Enable only changes between frames
            if (!in_frame) begin
                rx_enable <= cfg_rx_enable;
            end
            if (frame_good) begin
                stat_good_frames <= stat_good_frames + 1'b1;
            end
            if (frame_drop) begin
                stat_dropped_frames <= stat_dropped_frames + 1'b1;
            end
        end
    end

endmodule

//--- logic/rx_frame_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame FIFO with commit and rollback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "eth_rx_cfg.svh"

module rx_frame_fifo (
    input  logic                 rx_clk,
    input  logic                 rx_rst,
    input  eth_rx_pkg::rx_data_t fcs_data,
    input  eth_rx_pkg::rx_keep_t fcs_keep,
    input  logic                 fcs_valid,
    input  logic                 fcs_last,
    input  logic                 fcs_bad,
    input  logic                 fcs_err,
    output eth_rx_pkg::rx_data_t rx_axis_data,
    output eth_rx_pkg::rx_keep_t rx_axis_keep,
    output logic                 rx_axis_valid,
    output logic                 rx_axis_last,
    input  logic                 rx_axis_ready,
    output logic                 rx_error_bad_frame,
    output logic                 rx_error_bad_fcs,
    output logic                 rx_fifo_overflow,
    output logic                 rx_fifo_bad_frame,
    output logic                 rx_fifo_good_frame,
    output logic                 frame_good,
    output logic                 frame_drop
);
    import eth_rx_pkg::*;

    localparam int DEPTH = `ETH_RX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    rx_data_t       mem_data [DEPTH];
    rx_keep_t       mem_keep [DEPTH];
    logic           mem_last [DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] commit_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           ovf_flag;
    logic           full;
    logic           wr_en;
    logic           end_frame;
    logic           drop_ovf;
    logic           drop_bad;

    // Uncommitted words count against free space
    assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign wr_en     = fcs_valid && !ovf_flag && !full;
    assign end_frame = fcs_valid && fcs_last;
    assign drop_ovf  = end_frame && (ovf_flag || full);
    assign drop_bad  = end_frame && !drop_ovf && (fcs_err || fcs_bad);

    // Status pulses, all on the terminating word
    assign rx_error_bad_frame = end_frame && fcs_err;
    assign rx_error_bad_fcs   = end_frame && fcs_bad && !fcs_err;
    assign rx_fifo_overflow   = drop_ovf;
    assign rx_fifo_bad_frame  = drop_bad;
    assign rx_fifo_good_frame = end_frame && !drop_ovf && !drop_bad;
    assign frame_good         = rx_fifo_good_frame;
    assign frame_drop         = drop_ovf || drop_bad;

    // Only committed words are visible to the reader
    assign rx_axis_valid = (rd_ptr != commit_ptr);
    assign rx_axis_data  = mem_data[rd_ptr[PTR_W-1:0]];
    assign rx_axis_keep  = mem_keep[rd_ptr[PTR_W-1:0]];
    assign rx_axis_last  = mem_last[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge rx_clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[PTR_W-1:0]] <= fcs_data;
            mem_keep[wr_ptr[PTR_W-1:0]] <= fcs_keep;
            mem_last[wr_ptr[PTR_W-1:0]] <= fcs_last;
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            ovf_flag   <= 1'b0;
        end else begin
            if (end_frame) begin
                ovf_flag <= 1'b0;
                if (drop_ovf || drop_bad) begin
                    wr_ptr <= commit_ptr;
                end else begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end else if (fcs_valid) begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end else begin
                    ovf_flag <= 1'b1;
                end
            end
            if (rx_axis_valid && rx_axis_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- logic/eth_mac_rx_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10G receive MAC with frame FIFO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "eth_rx_cfg.svh"

module eth_mac_rx_fifo (
    input  logic                       rx_clk,
    input  logic                       rx_rst,
    input  eth_rx_pkg::rx_data_t       xgmii_rxd,
    input  eth_rx_pkg::xgmii_ctrl_t    xgmii_rxc,
    input  logic                       cfg_rx_enable,
    output eth_rx_pkg::rx_data_t       rx_axis_data,
    output eth_rx_pkg::rx_keep_t       rx_axis_keep,
    output logic                       rx_axis_valid,
    input  logic                       rx_axis_ready,
    output logic                       rx_axis_last,
    output logic                       rx_error_bad_frame,
    output logic                       rx_error_bad_fcs,
    output logic                       rx_fifo_overflow,
    output logic                       rx_fifo_bad_frame,
    output logic                       rx_fifo_good_frame,
    output logic [`ETH_STAT_WIDTH-1:0] stat_good_frames,
    output logic [`ETH_STAT_WIDTH-1:0] stat_dropped_frames
);
    import eth_rx_pkg::*;

    // Decoder to checker
    rx_data_t dec_data;
    rx_keep_t dec_keep;
    logic     dec_valid;
    logic     dec_last;
    logic     dec_err;

    // Checker to FIFO
    rx_data_t fcs_data;
    rx_keep_t fcs_keep;
    logic     fcs_valid;
    logic     fcs_last;
    logic     fcs_bad;
    logic     fcs_err;

    logic     in_frame;
    logic     rx_enable;
    logic     frame_good;
    logic     frame_drop;

    xgmii_rx_decode xgmii_rx_decode_inst (
        .rx_clk    (rx_clk),
        .rx_rst    (rx_rst),
        .xgmii_rxd (xgmii_rxd),
        .xgmii_rxc (xgmii_rxc),
        .rx_enable (rx_enable),
        .dec_data  (dec_data),
        .dec_keep  (dec_keep),
        .dec_valid (dec_valid),
        .dec_last  (dec_last),
        .dec_err   (dec_err),
        .in_frame  (in_frame)
    );

    rx_fcs_check rx_fcs_check_inst (
        .rx_clk    (rx_clk),
        .rx_rst    (rx_rst),
        .dec_data  (dec_data),
        .dec_keep  (dec_keep),
        .dec_valid (dec_valid),
        .dec_last  (dec_last),
        .dec_err   (dec_err),
        .fcs_data  (fcs_data),
        .fcs_keep  (fcs_keep),
        .fcs_valid (fcs_valid),
        .fcs_last  (fcs_last),
        .fcs_bad   (fcs_bad),
        .fcs_err   (fcs_err)
    );

    rx_frame_fifo rx_frame_fifo_inst (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .fcs_data           (fcs_data),
        .fcs_keep           (fcs_keep),
        .fcs_valid          (fcs_valid),
        .fcs_last           (fcs_last),
        .fcs_bad            (fcs_bad),
        .fcs_err            (fcs_err),
        .rx_axis_data       (rx_axis_data),
        .rx_axis_keep       (rx_axis_keep),
        .rx_axis_valid      (rx_axis_valid),
        .rx_axis_last       (rx_axis_last),
        .rx_axis_ready      (rx_axis_ready),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs),
        .rx_fifo_overflow   (rx_fifo_overflow),
        .rx_fifo_bad_frame  (rx_fifo_bad_frame),
        .rx_fifo_good_frame (rx_fifo_good_frame),
        .frame_good         (frame_good),
        .frame_drop         (frame_drop)
    );

    rx_ctrl_stats rx_ctrl_stats_inst (
        .rx_clk              (rx_clk),
        .rx_rst              (rx_rst),
        .cfg_rx_enable       (cfg_rx_enable),
        .in_frame            (in_frame),
        .frame_good          (frame_good),
        .frame_drop          (frame_drop),
        .rx_enable           (rx_enable),
        .stat_good_frames    (stat_good_frames),
        .stat_dropped_frames (stat_dropped_frames)
    );

endmodule

//--- testbench/eth_mac_rx_fifo_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output protocol assertions and bind
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module eth_mac_rx_fifo_assert (
    input logic                 rx_clk,
    input logic                 rx_rst,
    input eth_rx_pkg::rx_data_t rx_axis_data,
    input eth_rx_pkg::rx_keep_t rx_axis_keep,
    input logic                 rx_axis_valid,
    input logic                 rx_axis_ready,
    input logic                 rx_axis_last,
    input logic                 rx_fifo_good_frame,
    input logic                 rx_fifo_bad_frame,
    input logic                 rx_fifo_overflow
);

    int fail_count = 0;

    // Stalled word must hold until it transfers
    assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_axis_valid && !rx_axis_ready |=> rx_axis_valid && $stable(rx_axis_data) &&
            $stable(rx_axis_keep) && $stable(rx_axis_last))
    else begin
        $error("AXI output word changed while stalled");
        fail_count++;
    end

    assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_fifo_good_frame |-> !(rx_fifo_bad_frame || rx_fifo_overflow))
    else begin
        $error("Good frame pulse together with a drop pulse");
        fail_count++;
    end

    // Keep is contiguous from lane 0
    assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_axis_valid |-> rx_axis_keep inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
    else begin
        $error("Keep mask not contiguous or empty");
        fail_count++;
    end

endmodule

bind eth_mac_rx_fifo eth_mac_rx_fifo_assert eth_mac_rx_fifo_assert_inst (
    .rx_clk             (rx_clk),
    .rx_rst             (rx_rst),
    .rx_axis_data       (rx_axis_data),
    .rx_axis_keep       (rx_axis_keep),
    .rx_axis_valid      (rx_axis_valid),
    .rx_axis_ready      (rx_axis_ready),
    .rx_axis_last       (rx_axis_last),
    .rx_fifo_good_frame (rx_fifo_good_frame),
    .rx_fifo_bad_frame  (rx_fifo_bad_frame),
    .rx_fifo_overflow   (rx_fifo_overflow)
);

//--- testbench/tb_eth_mac_rx_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the receive MAC and FIFO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "eth_rx_cfg.svh"

module tb_eth_mac_rx_fifo;
    import eth_rx_pkg::*;

    localparam int LANES     = `ETH_RX_DATA_BYTES;
    localparam int MAX_TESTS = 32;
    localparam int MAX_BYTES = 256;

    logic                       rx_clk = 1'b0;
    logic                       rx_rst;
    rx_data_t                   xgmii_rxd;
    xgmii_ctrl_t                xgmii_rxc;
    logic                       cfg_rx_enable;
    rx_data_t                   rx_axis_data;
    rx_keep_t                   rx_axis_keep;
    logic                       rx_axis_valid;
    logic                       rx_axis_ready;
    logic                       rx_axis_last;
    logic                       rx_error_bad_frame;
    logic                       rx_error_bad_fcs;
    logic                       rx_fifo_overflow;
    logic                       rx_fifo_bad_frame;
    logic                       rx_fifo_good_frame;
    logic [`ETH_STAT_WIDTH-1:0] stat_good_frames;
    logic [`ETH_STAT_WIDTH-1:0] stat_dropped_frames;

    // Pattern table
    logic [8*16-1:0] names   [MAX_TESTS];
    int              lens    [MAX_TESTS];
    integer          seeds   [MAX_TESTS];
    logic [8*8-1:0]  faults  [MAX_TESTS];
    int              enables [MAX_TESTS];
    logic [8*8-1:0]  readys  [MAX_TESTS];
    logic [8*12-1:0] expects [MAX_TESTS];
    int              num_tests;

    logic [16*8-1:0] cur_name;
    logic [7:0]      frame_bytes [MAX_BYTES];
    int              frame_len;
    // Entry is {last, keep, data with unused lanes zeroed}
    logic [36:0]     exp_q [$];
    logic [36:0]     exp_word;
    logic [36:0]     act_word;
    integer          ready_seed;
    integer          ready_rnd;
    integer          pay_seed;
    integer          byte_rnd;
    int              ready_mode;
    int              cycle_cnt;
    int              cycle_limit;
    int              err_count;
    int              test_errs;
    int              tests_failed;
    int              exp_good_total;
    int              exp_drop_total;
    int              word_idx;
    int              n_good;
    int              n_bad;
    int              n_ovf;
    int              n_err_frame;
    int              n_err_fcs;
    logic            frame_end_seen;

    eth_mac_rx_fifo eth_mac_rx_fifo_inst (
        .rx_clk              (rx_clk),
        .rx_rst              (rx_rst),
        .xgmii_rxd           (xgmii_rxd),
        .xgmii_rxc           (xgmii_rxc),
        .cfg_rx_enable       (cfg_rx_enable),
        .rx_axis_data        (rx_axis_data),
        .rx_axis_keep        (rx_axis_keep),
        .rx_axis_valid       (rx_axis_valid),
        .rx_axis_ready       (rx_axis_ready),
        .rx_axis_last        (rx_axis_last),
        .rx_error_bad_frame  (rx_error_bad_frame),
        .rx_error_bad_fcs    (rx_error_bad_fcs),
        .rx_fifo_overflow    (rx_fifo_overflow),
        .rx_fifo_bad_frame   (rx_fifo_bad_frame),
        .rx_fifo_good_frame  (rx_fifo_good_frame),
        .stat_good_frames    (stat_good_frames),
        .stat_dropped_frames (stat_dropped_frames)
    );

    always #50 rx_clk = ~rx_clk;

    // Ready mode 0 holds it high, 1 randomizes it, 2 holds it low
    always @(posedge rx_clk) begin
        #10;
        if (ready_mode == 1) begin
            ready_rnd = $random(ready_seed);
            rx_axis_ready = ready_rnd[0];
        end else begin
            rx_axis_ready = (ready_mode == 0);
        end
    end

    always @(posedge rx_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic count_error();
        err_count++;
        test_errs++;
    endtask

    // Output words and status pulses sampled mid-cycle
    always @(negedge rx_clk) begin
        if (!rx_rst) begin
            if (rx_fifo_good_frame) n_good++;
            if (rx_fifo_bad_frame) n_bad++;
            if (rx_fifo_overflow) n_ovf++;
            if (rx_error_bad_frame) n_err_frame++;
            if (rx_error_bad_fcs) n_err_fcs++;
            if (rx_fifo_good_frame || rx_fifo_bad_frame || rx_fifo_overflow) begin
                frame_end_seen = 1'b1;
            end
            if (rx_axis_valid && rx_axis_ready) begin
                act_word = {rx_axis_last, rx_axis_keep, 32'h0};
                for (int i = 0; i < LANES; i++) begin
                    if (rx_axis_keep[i]) act_word[8*i +: 8] = rx_axis_data[8*i +: 8];
                end
                if (exp_q.size() == 0) begin
                    $display("Test %0s: output word %0d arrived when none was expected",
                             cur_name, word_idx);
                    count_error();
                end else begin
                    exp_word = exp_q.pop_front();
                    if (act_word != exp_word) begin
                        $display("FAIL %0s word %0d: expected %h actual %h",
                                 cur_name, word_idx, exp_word, act_word);
                        count_error();
                    end
                end
                word_idx++;
            end
        end
    end

    task automatic compare_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %0s %0s: expected %0d actual %0d", cur_name, what, expected, actual);
            count_error();
        end
    endtask

    task automatic load_patterns();
        integer          fd;
        integer          code;
        logic [8*16-1:0] tok;
        logic [8*128-1:0] rest;
        num_tests = 0;
        fd = $fopen("testbench/rx_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file testbench/rx_patterns.txt");
            count_error();
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                code = $fscanf(fd, "%s", tok);
                if (code == 1 && tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%d %d %s %d %s %s", lens[num_tests], seeds[num_tests],
                                   faults[num_tests], enables[num_tests], readys[num_tests],
                                   expects[num_tests]);
                    if (code != 6) begin
                        $display("Pattern line for %0s is incomplete", tok);
                        count_error();
                    end
                    names[num_tests] = tok;
                    cycle_limit += (lens[num_tests] / 4 + 20) * 3;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_xgmii(input rx_data_t d, input xgmii_ctrl_t c);
        @(posedge rx_clk);
        #10;
        xgmii_rxd = d;
        xgmii_rxc = c;
    endtask

    task automatic idle_cycle();
        drive_xgmii({LANES{XGMII_IDLE}}, '1);
    endtask

    // Payload bytes from the seed and an FCS appended LSB first
    task automatic prepare_frame(input int t);
        logic [31:0] crc;
        logic [36:0] entry;
        int          nw;
        pay_seed = seeds[t];
        crc = CRC_INIT;
        for (int i = 0; i < lens[t]; i++) begin
            byte_rnd = $random(pay_seed);
            frame_bytes[i] = byte_rnd[7:0];
            crc = crc32_byte(crc, frame_bytes[i]);
        end
        crc = ~crc;
        if (faults[t] == "fcs") crc = crc ^ 32'h1;
        for (int i = 0; i < 4; i++) begin
            frame_bytes[lens[t] + i] = crc[8*i +: 8];
        end
        frame_len = lens[t] + 4;
        if (expects[t] == "good") begin
            nw = (lens[t] + LANES - 1) / LANES;
            for (int w = 0; w < nw; w++) begin
                entry = '0;
                for (int i = 0; i < LANES; i++) begin
                    if (w * LANES + i < lens[t]) begin
                        entry[32 + i] = 1'b1;
                        entry[8*i +: 8] = frame_bytes[w * LANES + i];
                    end
                end
                entry[36] = (w == nw - 1);
                exp_q.push_back(entry);
            end
        end
    endtask

    task automatic transmit_frame(input int total, input logic ctrl_fault);
        rx_data_t    d;
        xgmii_ctrl_t c;
        int          idx;
        drive_xgmii({{3{8'h55}}, XGMII_START}, 4'b0001);
        drive_xgmii({ETH_SFD, {3{8'h55}}}, '0);
        for (int w = 0; w <= total / LANES; w++) begin
            for (int i = 0; i < LANES; i++) begin
                idx = w * LANES + i;
                if (idx < total) begin
                    d[8*i +: 8] = frame_bytes[idx];
                    c[i] = 1'b0;
                end else begin
                    d[8*i +: 8] = (idx == total) ? XGMII_TERM : XGMII_IDLE;
                    c[i] = 1'b1;
                end
                // Error character well inside the frame
                if (ctrl_fault && idx == 20) begin
                    d[8*i +: 8] = XGMII_ERROR;
                    c[i] = 1'b1;
                end
            end
            drive_xgmii(d, c);
        end
    endtask

    task automatic run_test(input int t);
        logic is_good;
        logic is_ignored;
        cur_name = names[t];
        test_errs = 0;
        word_idx = 0;
        n_good = 0;
        n_bad = 0;
        n_ovf = 0;
        n_err_frame = 0;
        n_err_fcs = 0;
        frame_end_seen = 1'b0;
        is_good = (expects[t] == "good");
        is_ignored = (expects[t] == "ignored");
        ready_mode = (readys[t] == "random") ? 1 : ((readys[t] == "low") ? 2 : 0);
        prepare_frame(t);
        idle_cycle();
        cfg_rx_enable = (enables[t] != 0);
        repeat (3) idle_cycle();
        transmit_frame(frame_len, faults[t] == "ctrl");
        if (is_ignored) begin
            repeat (12) idle_cycle();
        end else begin
            while (!frame_end_seen || exp_q.size() != 0) idle_cycle();
        end
        repeat (4) idle_cycle();
        compare_count("good frame pulses", is_good ? 1 : 0, n_good);
        compare_count("bad frame pulses",
                      (expects[t] == "bad_fcs" || expects[t] == "bad_frame") ? 1 : 0, n_bad);
        compare_count("overflow pulses", (expects[t] == "overflow") ? 1 : 0, n_ovf);
        compare_count("framing error pulses", (expects[t] == "bad_frame") ? 1 : 0, n_err_frame);
        compare_count("FCS error pulses", (expects[t] == "bad_fcs") ? 1 : 0, n_err_fcs);
        if (is_good) begin
            exp_good_total++;
        end else if (!is_ignored) begin
            exp_drop_total++;
        end
        if (test_errs == 0) begin
            $display("pass %0s", cur_name);
        end else begin
            $display("Test %0s finished with %0d failed checks", cur_name, test_errs);
            tests_failed++;
        end
    endtask

    initial begin
        xgmii_rxd = {LANES{XGMII_IDLE}};
        xgmii_rxc = '1;
        cfg_rx_enable = 1'b1;
        rx_axis_ready = 1'b1;
        rx_rst = 1'b1;
        ready_mode = 0;
        ready_seed = 86;
        cycle_cnt = 0;
        cycle_limit = 0;
        err_count = 0;
        test_errs = 0;
        tests_failed = 0;
        exp_good_total = 0;
        exp_drop_total = 0;
        frame_end_seen = 1'b0;
        load_patterns();
        repeat (4) @(posedge rx_clk);
        #10;
        rx_rst = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        cur_name = "statistics";
        compare_count("good frame counter", exp_good_total, int'(stat_good_frames));
        compare_count("dropped frame counter", exp_drop_total, int'(stat_dropped_frames));
        err_count += eth_mac_rx_fifo_inst.eth_mac_rx_fifo_assert_inst.fail_count;
        $display("Summary: %0d tests run, %0d tests failed, %0d failed checks",
                 num_tests, tests_failed, err_count);
        if (err_count == 0 && num_tests > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/rx_patterns.txt
# Columns: name, payload bytes without FCS, payload seed, fault (none fcs runt ctrl),
# cfg_rx_enable, ready mode (always random low), expected outcome
good_64    60  11 none 1 always good
good_65    61  12 none 1 always good
good_66    62  13 none 1 always good
good_67    63  14 none 1 always good
good_92    88  15 none 1 always good
good_120   116 16 none 1 always good
bad_fcs    76  21 fcs  1 always bad_fcs
runt_44    40  22 runt 1 always bad_frame
ctrl_char  72  23 ctrl 1 always bad_frame
disabled   64  31 none 0 always ignored
reenabled  68  32 none 1 always good
rand_65    61  41 none 1 random good
rand_98    94  42 none 1 random good
rand_87    83  43 none 1 random good
rand_120   116 44 none 1 random good
overflow   200 51 none 1 low    overflow
after_ovf  64  52 none 1 random good

//--- sim.f
+incdir+common
common/eth_rx_pkg.sv
mac_rx/xgmii_rx_decode.sv
mac_rx/rx_fcs_check.sv
logic/rx_ctrl_stats.sv
logic/rx_frame_fifo.sv
logic/eth_mac_rx_fifo.sv
testbench/eth_mac_rx_fifo_assert.sv
testbench/tb_eth_mac_rx_fifo.sv

//--- Bender.yml
package:
  name: eth_mac_rx_fifo

sources:
  - include_dirs:
      - common
    files:
      - common/eth_rx_pkg.sv
      - mac_rx/xgmii_rx_decode.sv
      - mac_rx/rx_fcs_check.sv
      - logic/rx_ctrl_stats.sv
      - logic/rx_frame_fifo.sv
      - logic/eth_mac_rx_fifo.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/eth_mac_rx_fifo_assert.sv
      - testbench/tb_eth_mac_rx_fifo.sv
